/* floppy_pkg.sv */
package floppy_pkg;

	////////////////////////////////////////////////////////////
	// I/O page map
	////////////////////////////////////////////////////////////

	localparam logic [15:0] IO_BASE = 16'hE000;
	localparam logic [7:0] IDLE_READ = 8'hFF;

	// port offsets inside the I/O page
	typedef enum logic [7:0] {
		PORT_MMCA        = 8'd0,
		PORT_SPDR        = 8'd1,
		PORT_SPSR        = 8'd2,
		PORT_JOY         = 8'd3,
		PORT_TXD         = 8'd4,
		PORT_CTL         = 8'd6,
		PORT_TMR1        = 8'd7,
		PORT_TMR2        = 8'd8,
		PORT_CPU_REQUEST = 8'd9,
		PORT_CPU_STATUS  = 8'd10,
		PORT_TRACK       = 8'd11,
		PORT_SECTOR      = 8'd12,
		PORT_LED         = 8'd16
	} io_port_e;

	// host view of the disk controller registers
	typedef enum logic [2:0] {
		HOST_SECTOR = 3'd1,
		HOST_TRACK  = 3'd2,
		HOST_CMD    = 3'd3
	} host_reg_e;

	////////////////////////////////////////////////////////////
	// timing
	////////////////////////////////////////////////////////////

	// enabled cycles per timer tick, scaled down from 100 Hz
	localparam int TIMER_DIV = 8;
	localparam int SPI_HALF = 2;
	localparam int UART_DIV = 16;

	typedef enum logic {SPI_IDLE, SPI_SHIFT} spi_state_e;
	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_state_e;

endpackage

/* io_bus_if.sv */
`timescale 1ns/10ps

interface io_bus_if import floppy_pkg::*; ();

	// one-cycle write strobe, already qualified by ce
	logic wr_stb;
	io_port_e wr_port;
	logic [7:0] wdata;
	// cpu clock enable level
	logic ce;

	modport decoder (
		output wr_stb,
		output wr_port,
		output wdata,
		output ce
	);

	modport periph (
		input wr_stb,
		input wr_port,
		input wdata,
		input ce
	);

endinterface

/* io_decode.sv */
`timescale 1ns/10ps

module io_decode import floppy_pkg::*; (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        ce,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_wr,
	output logic [7:0]  cpu_rdata,
	input  logic [5:0]  keyboard_keys,
	input  logic [7:0]  spi_rdata,
	input  logic        spi_busy,
	input  logic        uart_busy,
	input  logic [7:0]  tmr1_q,
	input  logic [7:0]  tmr2_q,
	input  logic [7:0]  mb_request,
	input  logic [7:0]  mb_track,
	input  logic [7:0]  mb_sector,
	output logic [7:0]  leds,
	io_bus_if.decoder   bus
);

	logic       io_page;
	io_port_e   port;
	logic       wr_stb;
	logic [7:0] rd_next;

	////////////////////////////////////////////////////////////
	// address decode
	////////////////////////////////////////////////////////////

	// the whole 256-byte page at IO_BASE belongs to the ports
	assign io_page = cpu_addr[15:8] == IO_BASE[15:8];
	assign port = io_port_e'(cpu_addr[7:0]);
	assign wr_stb = ce & cpu_wr & io_page;

	assign bus.wr_stb = wr_stb;
	assign bus.wr_port = port;
	assign bus.wdata = cpu_wdata;
	assign bus.ce = ce;

	// debug LEDs
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			leds <= 8'h00;
		end else if (wr_stb && port == PORT_LED) begin
			leds <= cpu_wdata;
		end
	end

	////////////////////////////////////////////////////////////
	// read side
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_next = IDLE_READ;
		if (io_page) begin
			case (port)
				PORT_SPDR:        rd_next = spi_rdata;
				// flag ports carry their bit in bit 0
				PORT_SPSR:        rd_next = {7'b0, spi_busy};
				PORT_CTL:         rd_next = {7'b0, uart_busy};
				PORT_JOY:         rd_next = {2'b0, keyboard_keys};
				PORT_TMR1:        rd_next = tmr1_q;
				PORT_TMR2:        rd_next = tmr2_q;
				PORT_CPU_REQUEST: rd_next = mb_request;
				PORT_TRACK:       rd_next = mb_track;
				PORT_SECTOR:      rd_next = mb_sector;
				default:          rd_next = IDLE_READ;
			endcase
		end
	end

	// registered, one clock behind the address
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cpu_rdata <= IDLE_READ;
		end else begin
			cpu_rdata <= rd_next;
		end
	end

endmodule

/* host_mailbox.sv */
`timescale 1ns/10ps

module host_mailbox import floppy_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	input  logic [2:0] host_addr,
	input  logic [7:0] host_wdata,
	input  logic       host_wr,
	output logic [7:0] host_rdata,
	io_bus_if.periph   bus,
	output logic [7:0] mb_request,
	output logic [7:0] mb_track,
	output logic [7:0] mb_sector
);

	host_reg_e  host_reg;
	logic [7:0] track;
	logic [7:0] sector;
	logic [7:0] cmd;
	logic [7:0] status;
	logic       busy;
	logic       status_wr;

	assign host_reg = host_reg_e'(host_addr);
	assign status_wr = bus.wr_stb && bus.wr_port == PORT_CPU_STATUS;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			track <= 8'h00;
			sector <= 8'h00;
			status <= 8'h00;
			busy <= 1'b0;
		end else begin
			// cpu completes the request
			if (status_wr) begin
				status <= bus.wdata;
				busy <= 1'b0;
			end
			// a new host command wins over a completion in the same cycle
			if (host_wr) begin
				case (host_reg)
					HOST_SECTOR: sector <= host_wdata;
					HOST_TRACK:  track <= host_wdata;
					HOST_CMD:    busy <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (host_wr && host_reg == HOST_CMD) begin
			cmd <= host_wdata;
		end
	end

	// host register face
	always_comb begin
		case (host_reg)
			HOST_SECTOR: host_rdata = sector;
			HOST_TRACK:  host_rdata = track;
			HOST_CMD:    host_rdata = {busy, status[6:0]};
			default:     host_rdata = IDLE_READ;
		endcase
	end

	assign mb_request = busy ? cmd : 8'h00;
	assign mb_track = track;
	assign mb_sector = sector;

	// only a status write from the cpu ends a request
	a_busy_fall: assert property (@(posedge clk) disable iff (!reset_n)
		$fell(busy) |-> $past(status_wr));

endmodule

/* io_timers.sv */
`timescale 1ns/10ps

module io_timers import floppy_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	io_bus_if.periph   bus,
	output logic [7:0] tmr1_q,
	output logic [7:0] tmr2_q
);

	localparam int PW = $clog2(TIMER_DIV);

	logic [PW-1:0] presc;
	logic          tick;
	logic [1:0]    load;
	logic [7:0]    cnt [2];

	// shared prescaler, advances only with ce
	assign tick = bus.ce && presc == PW'(TIMER_DIV - 1);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			presc <= '0;
		end else if (bus.ce) begin
			presc <= tick ? '0 : presc + 1'b1;
		end
	end

	assign load[0] = bus.wr_stb && bus.wr_port == PORT_TMR1;
	assign load[1] = bus.wr_stb && bus.wr_port == PORT_TMR2;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			cnt[0] <= 8'h00;
			cnt[1] <= 8'h00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (load[i]) begin
					cnt[i] <= bus.wdata;
				end else if (tick && cnt[i] != 8'h00) begin
					cnt[i] <= cnt[i] - 8'd1;
				end
			end
		end
	end

	assign tmr1_q = cnt[0];
	assign tmr2_q = cnt[1];

	// an expired timer stays expired until software reloads it
	for (genvar g = 0; g < 2; g++) begin : g_chk
		a_no_restart: assert property (@(posedge clk) disable iff (!reset_n)
			(cnt[g] != 8'h00 && $past(cnt[g]) == 8'h00) |-> $past(load[g]));
	end

endmodule

/* spi_master.sv */
`timescale 1ns/10ps

module spi_master import floppy_pkg::*; (
	input  logic       clk,
	input  logic       reset_n,
	io_bus_if.periph   bus,
	input  logic       sd_miso,
	output logic       sd_mosi,
	output logic       sd_sck,
	output logic       sd_cs,
	output logic [7:0] spi_rdata,
	output logic       spi_busy
);

	localparam int HW = $clog2(SPI_HALF) > 0 ? $clog2(SPI_HALF) : 1;

	spi_state_e state;
	logic [HW-1:0] half_cnt;
	logic [3:0]    edge_cnt;
	logic [7:0]    tx_sr;
	logic [7:0]    rx_sr;
	logic          half_done;

	assign half_done = half_cnt == HW'(SPI_HALF - 1);
	assign spi_busy = state == SPI_SHIFT;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= SPI_IDLE;
			sd_cs <= 1'b1;
			sd_sck <= 1'b0;
			sd_mosi <= 1'b0;
			half_cnt <= '0;
			edge_cnt <= 4'd0;
		end else begin
			// card select level
			if (bus.wr_stb && bus.wr_port == PORT_MMCA) begin
				sd_cs <= bus.wdata[0];
			end
			case (state)
				SPI_IDLE: begin
					if (bus.wr_stb && bus.wr_port == PORT_SPDR) begin
						// msb goes out before the first rising edge
						sd_mosi <= bus.wdata[7];
						half_cnt <= '0;
						edge_cnt <= 4'd0;
						state <= SPI_SHIFT;
					end
				end
				SPI_SHIFT: begin
					half_cnt <= half_done ? '0 : half_cnt + 1'b1;
					if (half_done) begin
						sd_sck <= ~sd_sck;
						edge_cnt <= edge_cnt + 4'd1;
						// falling edge: next bit out, or done after 16 edges
						if (sd_sck) begin
							if (edge_cnt == 4'd15) begin
								state <= SPI_IDLE;
							end else begin
								sd_mosi <= tx_sr[6];
							end
						end
					end
				end
				default: state <= SPI_IDLE;
			endcase
		end
	end

	// shift registers
	always_ff @(posedge clk) begin
		if (state == SPI_IDLE && bus.wr_stb && bus.wr_port == PORT_SPDR) begin
			tx_sr <= bus.wdata;
		end else if (state == SPI_SHIFT && half_done) begin
			if (!sd_sck) begin
				rx_sr <= {rx_sr[6:0], sd_miso};
			end else begin
				tx_sr <= {tx_sr[6:0], 1'b0};
			end
		end
	end

	assign spi_rdata = rx_sr;

	a_sck_idle: assert property (@(posedge clk) disable iff (!reset_n)
		state == SPI_IDLE |-> !sd_sck);

endmodule

/* uart_tx.sv */
`timescale 1ns/10ps

module uart_tx import floppy_pkg::*; (
	input  logic     clk,
	input  logic     reset_n,
	io_bus_if.periph bus,
	output logic     uart_txd,
	output logic     uart_busy
);

	localparam int DW = $clog2(UART_DIV);

	uart_state_e   state;
	logic [DW-1:0] div;
	logic [2:0]    bit_idx;
	logic [7:0]    tx_sr;
	logic          bit_end;

	assign bit_end = div == DW'(UART_DIV - 1);
	assign uart_busy = state != TX_IDLE;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= TX_IDLE;
			uart_txd <= 1'b1;
			div <= '0;
		end else if (state == TX_IDLE) begin
			// start bit begins right at the write
			if (bus.wr_stb && bus.wr_port == PORT_TXD) begin
				uart_txd <= 1'b0;
				div <= '0;
				state <= TX_START;
			end
		end else begin
			div <= bit_end ? '0 : div + 1'b1;
			if (bit_end) begin
				case (state)
					TX_START: begin
						uart_txd <= tx_sr[0];
						state <= TX_DATA;
					end
					TX_DATA: begin
						uart_txd <= bit_idx == 3'd7 ? 1'b1 : tx_sr[1];
						if (bit_idx == 3'd7) state <= TX_STOP;
					end
					default: state <= TX_IDLE;
				endcase
			end
		end
	end

	// data path, lsb first
	always_ff @(posedge clk) begin
		if (state == TX_IDLE) begin
			tx_sr <= bus.wdata;
			bit_idx <= 3'd0;
		end else if (state == TX_DATA && bit_end) begin
			tx_sr <= {1'b0, tx_sr[7:1]};
			bit_idx <= bit_idx + 3'd1;
		end
	end

	a_line_idle: assert property (@(posedge clk) disable iff (!reset_n)
		state == TX_IDLE |-> uart_txd);

endmodule

/* floppy_io.sv */
`timescale 1ns/10ps

module floppy_io (
	input  logic        clk,
	input  logic        reset_n,
	input  logic        ce,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	input  logic        cpu_wr,
	output logic [7:0]  cpu_rdata,
	input  logic [2:0]  host_addr,
	input  logic [7:0]  host_wdata,
	input  logic        host_wr,
	output logic [7:0]  host_rdata,
	input  logic [5:0]  keyboard_keys,
	output logic [7:0]  leds,
	input  logic        sd_miso,
	output logic        sd_mosi,
	output logic        sd_sck,
	output logic        sd_cs,
	output logic        uart_txd
);

	logic [7:0] spi_rdata;
	logic       spi_busy;
	logic       uart_busy;
	logic [7:0] tmr1_q;
	logic [7:0] tmr2_q;
	logic [7:0] mb_request;
	logic [7:0] mb_track;
	logic [7:0] mb_sector;

	io_bus_if bus ();

	////////////////////////////////////////////////////////////
	// input side
	////////////////////////////////////////////////////////////

	io_decode io_decode_i (
		.clk(clk), .reset_n(reset_n), .ce(ce),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wr(cpu_wr),
		.cpu_rdata(cpu_rdata), .keyboard_keys(keyboard_keys),
		.spi_rdata(spi_rdata), .spi_busy(spi_busy), .uart_busy(uart_busy),
		.tmr1_q(tmr1_q), .tmr2_q(tmr2_q),
		.mb_request(mb_request), .mb_track(mb_track), .mb_sector(mb_sector),
		.leds(leds), .bus(bus.decoder)
	);

	host_mailbox host_mailbox_i (
		.clk(clk), .reset_n(reset_n),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_wr(host_wr),
		.host_rdata(host_rdata), .bus(bus.periph),
		.mb_request(mb_request), .mb_track(mb_track), .mb_sector(mb_sector)
	);

	io_timers io_timers_i (
		.clk(clk), .reset_n(reset_n), .bus(bus.periph),
		.tmr1_q(tmr1_q), .tmr2_q(tmr2_q)
	);

	////////////////////////////////////////////////////////////
	// output side
	////////////////////////////////////////////////////////////

	spi_master spi_master_i (
		.clk(clk), .reset_n(reset_n), .bus(bus.periph),
		.sd_miso(sd_miso), .sd_mosi(sd_mosi), .sd_sck(sd_sck), .sd_cs(sd_cs),
		.spi_rdata(spi_rdata), .spi_busy(spi_busy)
	);

	uart_tx uart_tx_i (
		.clk(clk), .reset_n(reset_n), .bus(bus.periph),
		.uart_txd(uart_txd), .uart_busy(uart_busy)
	);

endmodule

/* tb_floppy_io.sv */
`timescale 1ns/10ps

module tb_floppy_io import floppy_pkg::*; ();

	// about twice the cycles the full sequence needs
	localparam int MAX_CYCLES = 3000;
	localparam int SPI_BYTES = 4;
	localparam int UART_BYTES = 4;

	logic        clk;
	logic        reset_n;
	logic        ce;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_wr;
	logic [7:0]  cpu_rdata;
	logic [2:0]  host_addr;
	logic [7:0]  host_wdata;
	logic        host_wr;
	logic [7:0]  host_rdata;
	logic [5:0]  keyboard_keys;
	logic [7:0]  leds;
	logic        sd_miso = 1'b0;
	logic        sd_mosi;
	logic        sd_sck;
	logic        sd_cs;
	logic        uart_txd;

	string       test_name;
	int          cycles = 0;
	logic [7:0]  lfsr = 8'd56;

	// register model
	logic [7:0]  m_spi_rx;
	logic [7:0]  m_tmr [2];
	logic [7:0]  m_track;
	logic [7:0]  m_sector;
	logic [7:0]  m_cmd;
	logic [7:0]  m_status;
	logic        m_busy;

	// sd card side
	logic [7:0]  slave_tx;
	logic        slave_load;
	logic [7:0]  slave_sr;
	logic [7:0]  mosi_cap;
	logic        sck_q = 1'b0;

	logic [7:0]  uart_expect [$];

	floppy_io floppy_io_i (
		.clk(clk), .reset_n(reset_n), .ce(ce),
		.cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wr(cpu_wr), .cpu_rdata(cpu_rdata),
		.host_addr(host_addr), .host_wdata(host_wdata), .host_wr(host_wr),
		.host_rdata(host_rdata), .keyboard_keys(keyboard_keys), .leds(leds),
		.sd_miso(sd_miso), .sd_mosi(sd_mosi), .sd_sck(sd_sck), .sd_cs(sd_cs),
		.uart_txd(uart_txd)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout: tests still running after %0d cycles", MAX_CYCLES);
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////
	// sd card model, mode 0
	////////////////////////////////////////////////////////////

	// edges seen one clock late, miso ready well before the next rise
	always @(posedge clk) begin
		sck_q <= sd_sck;
		if (slave_load) begin
			slave_sr <= {slave_tx[6:0], 1'b0};
			sd_miso <= slave_tx[7];
		end else if (!sd_sck && sck_q) begin
			sd_miso <= slave_sr[7];
			slave_sr <= {slave_sr[6:0], 1'b0};
		end
		if (sd_sck && !sck_q) begin
			mosi_cap <= {mosi_cap[6:0], sd_mosi};
		end
	end

	// uart receiver, samples mid bit
	always begin : uart_rx
		logic [7:0] frame;
		@(posedge clk);
		if (reset_n && uart_txd == 1'b0) begin
			repeat (UART_DIV / 2 - 1) @(posedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (UART_DIV) @(posedge clk);
				frame[i] = uart_txd;
			end
			repeat (UART_DIV) @(posedge clk);
			if (uart_txd != 1'b1 || uart_expect.size() == 0) begin
				$display("UART frame has no stop bit or was never sent");
				abort_run();
			end
			check_byte("uart frame", uart_expect.pop_front(), frame);
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {1'b0, s[7:1]} ^ (s[0] ? 8'hB8 : 8'h00);
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] r;
		r = 8'h00;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [15:0] port_addr(input io_port_e p);
		return {IO_BASE[15:8], p};
	endfunction

	function automatic logic [7:0] expected_read(input io_port_e p);
		case (p)
			PORT_SPDR:        return m_spi_rx;
			// flags are compared only once polled idle
			PORT_SPSR:        return 8'h00;
			PORT_CTL:         return 8'h00;
			PORT_JOY:         return {2'b00, keyboard_keys};
			PORT_TMR1:        return m_tmr[0];
			PORT_TMR2:        return m_tmr[1];
			PORT_CPU_REQUEST: return m_busy ? m_cmd : 8'h00;
			PORT_TRACK:       return m_track;
			PORT_SECTOR:      return m_sector;
			default:          return IDLE_READ;
		endcase
	endfunction

	function automatic logic [7:0] expected_host(input host_reg_e r);
		case (r)
			HOST_SECTOR: return m_sector;
			HOST_TRACK:  return m_track;
			HOST_CMD:    return {m_busy, m_status[6:0]};
			default:     return IDLE_READ;
		endcase
	endfunction

	task automatic abort_run();
		$display("TEST FAIL");
		$fatal(1, "run aborted");
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Error in %s: %s expected %02h actual %02h", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic check_port(input io_port_e p, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("Error in %s: port %s expected %02h actual %02h",
				test_name, p.name(), exp, act);
			abort_run();
		end
	endtask

	task automatic expect_level(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("Error in %s: %s expected %b actual %b", test_name, what, exp, act);
			abort_run();
		end
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		@(posedge clk);
		cpu_addr <= a;
		cpu_wdata <= d;
		cpu_wr <= 1'b1;
		@(posedge clk);
		cpu_wr <= 1'b0;
	endtask

	// data is registered, so sample a full clock after the address
	task automatic cpu_read(input logic [15:0] a, output logic [7:0] d);
		@(posedge clk);
		cpu_addr <= a;
		cpu_wr <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		d = cpu_rdata;
	endtask

	task automatic verify_port(input io_port_e p);
		logic [7:0] d;
		cpu_read(port_addr(p), d);
		check_port(p, expected_read(p), d);
	endtask

	task automatic wait_idle(input io_port_e p);
		logic [7:0] d;
		d = 8'h01;
		while (d[0]) begin
			cpu_read(port_addr(p), d);
		end
	endtask

	task automatic host_write(input host_reg_e r, input logic [7:0] d);
		@(posedge clk);
		host_addr <= r;
		host_wdata <= d;
		host_wr <= 1'b1;
		@(posedge clk);
		host_wr <= 1'b0;
	endtask

	task automatic host_check(input host_reg_e r);
		@(posedge clk);
		host_addr <= r;
		@(negedge clk);
		check_byte(r.name(), expected_host(r), host_rdata);
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [7:0] d;
		logic [7:0] b;
		logic [7:0] s;
		logic [7:0] n;
		io_port_e   p;
		reset_n = 1'b0;
		ce = 1'b1;
		cpu_addr = 16'h0000;
		cpu_wdata = 8'h00;
		cpu_wr = 1'b0;
		host_addr = 3'd0;
		host_wdata = 8'h00;
		host_wr = 1'b0;
		keyboard_keys = 6'd0;
		slave_tx = 8'h00;
		slave_load = 1'b0;
		m_tmr[0] = 8'h00;
		m_tmr[1] = 8'h00;
		m_track = 8'h00;
		m_sector = 8'h00;
		m_cmd = 8'h00;
		m_status = 8'h00;
		m_busy = 1'b0;
		repeat (16) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);

		test_name = "reset";
		expect_level("sd_cs", 1'b1, sd_cs);
		expect_level("sd_sck", 1'b0, sd_sck);
		expect_level("sd_mosi", 1'b0, sd_mosi);
		expect_level("uart_txd", 1'b1, uart_txd);
		check_byte("leds", 8'h00, leds);
		check_byte("cpu_rdata", IDLE_READ, cpu_rdata);
		verify_port(PORT_SPSR);
		verify_port(PORT_CTL);
		verify_port(PORT_TMR1);
		verify_port(PORT_TMR2);
		verify_port(PORT_CPU_REQUEST);
		host_check(HOST_CMD);

		test_name = "decode";
		cpu_read(IO_BASE | 16'h0005, d);
		check_byte("unmapped port 05", IDLE_READ, d);
		cpu_read(IO_BASE | 16'h00F0, d);
		check_byte("unmapped port f0", IDLE_READ, d);
		b = rand_bits(6);
		@(posedge clk);
		keyboard_keys <= b[5:0];
		verify_port(PORT_JOY);
		repeat (3) begin
			b = rand_bits(8);
			cpu_write(port_addr(PORT_LED), b);
			@(negedge clk);
			check_byte("leds", b, leds);
		end
		// write with ce low must be dropped
		@(posedge clk);
		ce <= 1'b0;
		cpu_write(port_addr(PORT_LED), ~b);
		@(posedge clk);
		ce <= 1'b1;
		@(negedge clk);
		check_byte("leds after ce low write", b, leds);

		test_name = "spi";
		cpu_write(port_addr(PORT_MMCA), 8'h00);
		@(negedge clk);
		expect_level("sd_cs", 1'b0, sd_cs);
		repeat (SPI_BYTES) begin
			b = rand_bits(8);
			s = rand_bits(8);
			@(posedge clk);
			slave_tx <= s;
			slave_load <= 1'b1;
			@(posedge clk);
			slave_load <= 1'b0;
			cpu_write(port_addr(PORT_SPDR), b);
			cpu_read(port_addr(PORT_SPSR), d);
			check_port(PORT_SPSR, 8'h01, d);
			wait_idle(PORT_SPSR);
			m_spi_rx = s;
			check_byte("mosi byte", b, mosi_cap);
			verify_port(PORT_SPDR);
		end
		cpu_write(port_addr(PORT_MMCA), 8'h01);
		@(negedge clk);
		expect_level("sd_cs", 1'b1, sd_cs);

		test_name = "uart";
		repeat (UART_BYTES) begin
			b = rand_bits(8);
			uart_expect.push_back(b);
			cpu_write(port_addr(PORT_TXD), b);
			wait_idle(PORT_CTL);
			if (uart_expect.size() != 0) begin
				$display("UART frame was not received before busy fell");
				abort_run();
			end
			verify_port(PORT_CTL);
		end

		test_name = "timers";
		for (int t = 0; t < 2; t++) begin
			if (t == 0) begin
				p = PORT_TMR1;
			end else begin
				p = PORT_TMR2;
			end
			n = (rand_bits(4) % 8'd15) + 8'd1;
			cpu_write(port_addr(p), n);
			// prescaler held, count reads back as loaded
			ce <= 1'b0;
			m_tmr[t] = n;
			verify_port(p);
			@(posedge clk);
			ce <= 1'b1;
			repeat ((n + 2) * TIMER_DIV) @(posedge clk);
			m_tmr[t] = 8'h00;
			verify_port(p);
		end

		test_name = "mailbox";
		m_track = rand_bits(8);
		host_write(HOST_TRACK, m_track);
		m_sector = rand_bits(8);
		host_write(HOST_SECTOR, m_sector);
		m_cmd = rand_bits(8);
		host_write(HOST_CMD, m_cmd);
		m_busy = 1'b1;
		verify_port(PORT_TRACK);
		verify_port(PORT_SECTOR);
		verify_port(PORT_CPU_REQUEST);
		host_check(HOST_CMD);
		host_check(HOST_TRACK);
		host_check(HOST_SECTOR);
		m_status = rand_bits(8);
		cpu_write(port_addr(PORT_CPU_STATUS), m_status);
		m_busy = 1'b0;
		verify_port(PORT_CPU_REQUEST);
		host_check(HOST_CMD);

		$display("TEST PASS");
		$finish;
	end

endmodule

/* floppy_io.f */
floppy_pkg.sv
io_bus_if.sv
io_decode.sv
host_mailbox.sv
io_timers.sv
spi_master.sv
uart_tx.sv
floppy_io.sv
tb_floppy_io.sv

/* Makefile */
TOP = tb_floppy_io

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f floppy_io.f

# pass only if the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f floppy_io.f

clean:
	rm -rf obj_dir sim.log
